//--- flist.f
kyber_frame_pkg.sv
hash_word_if.sv
seed_framer.sv
pk_absorber.sv
sponge_arbiter.sv
kyber_hash_frontend.sv
tb_kyber_hash_frontend.sv

//--- Bender.yml
package:
  name: kyber_hash_frontend

sources:
  - kyber_frame_pkg.sv
  - hash_word_if.sv
  - seed_framer.sv
  - pk_absorber.sv
  - sponge_arbiter.sv
  - kyber_hash_frontend.sv
  - target: test
    files:
      - tb_kyber_hash_frontend.sv

//--- tb_kyber_hash_frontend.sv
`timescale 1ns/10ps
`default_nettype none

module tb_kyber_hash_frontend
	import kyber_frame_pkg::*;
();

	typedef enum int {
		msg_xof,
		msg_prf,
		msg_pk
	} msg_kind_t;

	logic         clk;
	logic         rst;
	logic         seed_valid;
	logic         seed_ready;
	seed_t        seed_data;
	logic         seed_xof;
	logic [3:0]   nonce;
	logic [1:0]   row;
	logic [1:0]   col;
	logic         pk_start;
	rank_t        k;
	logic         pk_busy;
	logic         pk_valid;
	logic         pk_ready;
	word_t        pk_data;
	logic         hash_valid;
	logic         hash_ready;
	word_t        hash_data;
	sponge_mode_t hash_mode;
	logic         hash_block_last;
	logic         hash_msg_last;

	// job data the expected messages are built from
	seed_t      exp_seed;
	logic [3:0] exp_nonce;
	logic [1:0] exp_row;
	logic [1:0] exp_col;
	rank_t      exp_k;
	word_t      key_mem [0:4*96+7];
	msg_kind_t  kind_q [$];
	hash_word_t exp_w;
	int         word_idx;
	int         msgs_done;
	int         mismatches;
	int         other_errors;
	int         cycles;
	int         max_cycles;
	logic       stall_en;
	word_t      data_rng;
	word_t      stall_rng;

	kyber_hash_frontend i_dut (.*);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic word_t lcg_next(input word_t s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic int msg_len(input msg_kind_t kind);
		case (kind)
			msg_xof: return RATE_SHAKE128_WORDS;
			msg_prf: return RATE_SHAKE256_WORDS;
			default: return int'(pk_total_words(exp_k));
		endcase
	endfunction

	function automatic hash_word_t expected_word(input msg_kind_t kind, input int idx);
		hash_word_t w;
		int len;
		len = msg_len(kind);
		w.data = '0;
		w.msg_last = (idx == len - 1);
		if (kind == msg_pk) begin
			w.mode = sha3_256;
			w.block_last = (idx % RATE_SHA3_256_WORDS) == RATE_SHA3_256_WORDS - 1;
			if (idx < int'(pk_words(exp_k)))
				w.data = key_mem[idx];
			else if (idx == int'(pk_words(exp_k)))
				w.data = DOMAIN_SHA3_WORD;
		end else begin
			w.mode = (kind == msg_xof) ? shake128 : shake256;
			w.block_last = w.msg_last;
			if (idx < SEED_WORDS)
				w.data = exp_seed[idx*32 +: 32];
			else if (idx == SEED_WORDS && kind == msg_xof)
				w.data = (32'(SHAKE_SUFFIX) << 16) | (32'(exp_col) << 8) | 32'(exp_row);
			else if (idx == SEED_WORDS)
				w.data = (32'(SHAKE_SUFFIX) << 8) | 32'(exp_nonce);
		end
		if (w.msg_last)
			w.data = PAD_END_WORD;
		return w;
	endfunction

	task automatic check_word(input string name, input word_t act, input word_t exp);
		if (act !== exp) begin
			$display("MISMATCH at %0t: %s got %h, expected %h", $time, name, act, exp);
			mismatches++;
		end
	endtask

	task automatic check_mode(input string name, input sponge_mode_t act,
			input sponge_mode_t exp);
		if (act !== exp) begin
			$display("MISMATCH at %0t: %s got %h, expected %h", $time, name, act, exp);
			mismatches++;
		end
	endtask

	task automatic check_flag(input string name, input logic act, input logic exp);
		if (act !== exp) begin
			$display("MISMATCH at %0t: %s got %b, expected %b", $time, name, act, exp);
			mismatches++;
		end
	endtask

	// every output transfer is compared against the head message
	always @(posedge clk) begin
		if (!rst && hash_valid === 1'b1 && hash_ready === 1'b1) begin
			if (kind_q.size() == 0) begin
				$display("word %h at %0t arrived while no message was expected",
					hash_data, $time);
				other_errors++;
			end else begin
				exp_w = expected_word(kind_q[0], word_idx);
				check_word("hash_data", hash_data, exp_w.data);
				check_mode("hash_mode", hash_mode, exp_w.mode);
				check_flag("hash_block_last", hash_block_last, exp_w.block_last);
				check_flag("hash_msg_last", hash_msg_last, exp_w.msg_last);
				if (exp_w.msg_last) begin
					kind_q.delete(0);
					word_idx = 0;
					msgs_done++;
				end else begin
					word_idx++;
				end
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > max_cycles) begin
			$display("timeout after %0d cycles, %0d messages never finished",
				cycles, kind_q.size());
			$display("ERRORS FOUND");
			$finish;
		end
	end

	// sink back-pressure, roughly one stalled cycle in four
	always @(negedge clk) begin
		if (stall_en) begin
			stall_rng = lcg_next(stall_rng);
			hash_ready = (stall_rng[31:30] != 2'b00);
		end else begin
			hash_ready = 1'b1;
		end
	end

	task automatic new_seed();
		int i;
		for (i = 0; i < SEED_WORDS; i++) begin
			data_rng = lcg_next(data_rng);
			exp_seed[i*32 +: 32] = data_rng;
		end
	endtask

	task automatic new_key(input rank_t kv);
		int i;
		exp_k = kv;
		for (i = 0; i < int'(pk_words(kv)); i++) begin
			data_rng = lcg_next(data_rng);
			key_mem[i] = data_rng;
		end
	endtask

	task automatic run_seed_job(input logic xof, input logic [3:0] n,
			input logic [1:0] r, input logic [1:0] c);
		@(negedge clk);
		seed_valid = 1'b1;
		seed_data = exp_seed;
		seed_xof = xof;
		nonce = n;
		row = r;
		col = c;
		exp_nonce = n;
		exp_row = r;
		exp_col = c;
		do
			@(posedge clk);
		while (seed_ready !== 1'b1);
		@(negedge clk);
		seed_valid = 1'b0;
	endtask

	task automatic run_pk_job(input rank_t kv);
		int idx;
		idx = 0;
		@(negedge clk);
		k = kv;
		pk_start = 1'b1;
		pk_valid = 1'b1;
		pk_data = key_mem[0];
		@(posedge clk);
		@(negedge clk);
		pk_start = 1'b0;
		check_flag("pk_busy", pk_busy, 1'b1);
		while (idx < int'(pk_words(kv))) begin
			@(posedge clk);
			if (pk_ready === 1'b1)
				idx++;
			@(negedge clk);
			if (idx < int'(pk_words(kv)))
				pk_data = key_mem[idx];
			else
				pk_valid = 1'b0;
		end
	endtask

	// the head message leaves the queue on its msg_last transfer
	task automatic wait_idle();
		while (kind_q.size() != 0)
			@(negedge clk);
		check_flag("pk_busy", pk_busy, 1'b0);
		check_flag("seed_ready", seed_ready, 1'b1);
	endtask

	initial begin
		rank_t kv;
		int n;
		rst = 1'b1;
		seed_valid = 1'b0;
		seed_data = '0;
		seed_xof = 1'b0;
		nonce = '0;
		row = '0;
		col = '0;
		pk_start = 1'b0;
		k = 3'd2;
		pk_valid = 1'b0;
		pk_data = '0;
		hash_ready = 1'b1;
		stall_en = 1'b0;
		data_rng = 32'd17;
		stall_rng = 32'd17;
		word_idx = 0;
		msgs_done = 0;
		mismatches = 0;
		other_errors = 0;
		cycles = 0;
		max_cycles = 4 * (3 * RATE_SHAKE128_WORDS + 5 * RATE_SHAKE256_WORDS
			+ 2 * pk_total_words(2) + 2 * pk_total_words(3) + pk_total_words(4)) + 200;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		check_flag("hash_valid", hash_valid, 1'b0);
		check_flag("pk_ready", pk_ready, 1'b0);
		check_flag("pk_busy", pk_busy, 1'b0);
		check_flag("seed_ready", seed_ready, 1'b1);

		// xof job with random matrix indices
		new_seed();
		data_rng = lcg_next(data_rng);
		kind_q.push_back(msg_xof);
		run_seed_job(1'b1, data_rng[23:20], data_rng[31:30], data_rng[29:28]);
		wait_idle();

		for (n = 0; n < 4; n++) begin
			new_seed();
			kind_q.push_back(msg_prf);
			run_seed_job(1'b0, 4'(n), 2'd3, 2'd3);
			wait_idle();
		end

		for (kv = 3'd2; kv <= 3'd4; kv++) begin
			new_key(kv);
			kind_q.push_back(msg_pk);
			run_pk_job(kv);
			wait_idle();
		end

		stall_en = 1'b1;
		new_seed();
		data_rng = lcg_next(data_rng);
		kind_q.push_back(msg_xof);
		run_seed_job(1'b1, data_rng[23:20], data_rng[27:26], data_rng[25:24]);
		wait_idle();
		new_seed();
		kind_q.push_back(msg_prf);
		run_seed_job(1'b0, 4'd9, 2'd0, 2'd0);
		wait_idle();
		new_key(3'd3);
		kind_q.push_back(msg_pk);
		run_pk_job(3'd3);
		wait_idle();
		stall_en = 1'b0;

		// both jobs on one cycle, the public key goes first
		new_seed();
		new_key(3'd2);
		data_rng = lcg_next(data_rng);
		kind_q.push_back(msg_pk);
		kind_q.push_back(msg_xof);
		fork
			run_pk_job(3'd2);
			run_seed_job(1'b1, 4'd0, data_rng[31:30], data_rng[29:28]);
		join
		wait_idle();

		repeat (5) @(negedge clk);
		$display("%0d messages checked, %0d mismatches, %0d other errors",
			msgs_done, mismatches, other_errors);
		if (mismatches + other_errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

`default_nettype wire

//--- kyber_hash_frontend.sv
`timescale 1ns/10ps
`default_nettype none

module kyber_hash_frontend
	import kyber_frame_pkg::*;
(
	input  logic         clk,
	input  logic         rst,
	// seed job
	input  logic         seed_valid,
	output logic         seed_ready,
	input  seed_t        seed_data,
	input  logic         seed_xof,
	input  logic [3:0]   nonce,
	input  logic [1:0]   row,
	input  logic [1:0]   col,
	// public key job
	input  logic         pk_start,
	input  rank_t        k,
	output logic         pk_busy,
	input  logic         pk_valid,
	output logic         pk_ready,
	input  word_t        pk_data,
	// framed words towards the sponge core
	output logic         hash_valid,
	input  logic         hash_ready,
	output word_t        hash_data,
	output sponge_mode_t hash_mode,
	output logic         hash_block_last,
	output logic         hash_msg_last
);

	hash_word_if seed_if ();
	hash_word_if pk_if ();

	seed_framer i_seed_framer (
		.clk        (clk),
		.rst        (rst),
		.seed_valid (seed_valid),
		.seed_ready (seed_ready),
		.seed_data  (seed_data),
		.seed_xof   (seed_xof),
		.nonce      (nonce),
		.row        (row),
		.col        (col),
		.out        (seed_if.source)
	);

	pk_absorber i_pk_absorber (
		.clk      (clk),
		.rst      (rst),
		.pk_start (pk_start),
		.k        (k),
		.pk_busy  (pk_busy),
		.pk_valid (pk_valid),
		.pk_ready (pk_ready),
		.pk_data  (pk_data),
		.out      (pk_if.source)
	);

	sponge_arbiter i_sponge_arbiter (
		.clk             (clk),
		.rst             (rst),
		.pk_src          (pk_if.sink),
		.seed_src        (seed_if.sink),
		.hash_valid      (hash_valid),
		.hash_ready      (hash_ready),
		.hash_data       (hash_data),
		.hash_mode       (hash_mode),
		.hash_block_last (hash_block_last),
		.hash_msg_last   (hash_msg_last)
	);

endmodule

`default_nettype wire

//--- sponge_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

module sponge_arbiter
	import kyber_frame_pkg::*;
(
	input  logic         clk,
	input  logic         rst,
	hash_word_if.sink    pk_src,
	hash_word_if.sink    seed_src,
	output logic         hash_valid,
	input  logic         hash_ready,
	output word_t        hash_data,
	output sponge_mode_t hash_mode,
	output logic         hash_block_last,
	output logic         hash_msg_last
);

	typedef enum logic [1:0] {
		gnt_idle,
		gnt_pk,
		gnt_seed
	} grant_t;

	grant_t     grant;
	logic       sel_pk;
	logic       sel_seed;
	logic       fire;
	hash_word_t out_word;

	// public key wins a tie while idle
	assign sel_pk = (grant == gnt_pk) || (grant == gnt_idle && pk_src.valid);
	assign sel_seed = (grant == gnt_seed) ||
		(grant == gnt_idle && !pk_src.valid && seed_src.valid);

	assign out_word = sel_pk ? pk_src.word : seed_src.word;

	always_comb begin
		if (sel_pk)
			hash_valid = pk_src.valid;
		else if (sel_seed)
			hash_valid = seed_src.valid;
		else
			hash_valid = 1'b0;
	end

	assign hash_data = out_word.data;
	assign hash_mode = out_word.mode;
	assign hash_block_last = out_word.block_last;
	assign hash_msg_last = out_word.msg_last;

	// the waiting source sees ready low until the running message ends
	assign pk_src.ready = sel_pk && hash_ready;
	assign seed_src.ready = sel_seed && hash_ready;

	assign fire = hash_valid && hash_ready;

	always_ff @(posedge clk) begin
		if (rst) begin
			grant <= gnt_idle;
		end else if (fire && out_word.msg_last) begin
			grant <= gnt_idle;
		end else if (grant == gnt_idle) begin
			// lock as soon as a word is presented, even if stalled
			if (pk_src.valid)
				grant <= gnt_pk;
			else if (seed_src.valid)
				grant <= gnt_seed;
		end
	end

	// a source keeps the grant for as long as its message is running
	a_pk_lock: assert property (@(posedge clk) disable iff (rst)
		grant == gnt_pk && pk_src.busy |=> grant == gnt_pk || !pk_src.busy);

	a_seed_lock: assert property (@(posedge clk) disable iff (rst)
		grant == gnt_seed && seed_src.busy |=> grant == gnt_seed || !seed_src.busy);

endmodule

`default_nettype wire

//--- pk_absorber.sv
`timescale 1ns/10ps
`default_nettype none

module pk_absorber
	import kyber_frame_pkg::*;
(
	input  logic        clk,
	input  logic        rst,
	input  logic        pk_start,
	input  rank_t       k,
	output logic        pk_busy,
	input  logic        pk_valid,
	output logic        pk_ready,
	input  word_t       pk_data,
	hash_word_if.source out
);

	typedef enum logic [2:0] {
		st_idle,
		st_data,
		st_domain,
		st_zero,
		st_final
	} state_t;

	state_t     state;
	rank_t      k_q;
	logic [5:0] blk_cnt;
	logic [8:0] total_cnt;
	logic [8:0] data_len;
	logic [8:0] total_len;
	logic       word_valid;
	logic       fire;
	hash_word_t word;

	// message lengths follow the latched rank
	assign data_len = 9'(pk_words(k_q));
	assign total_len = 9'(pk_total_words(k_q));

	assign pk_busy = (state != st_idle);
	assign fire = word_valid && out.ready;

	// key words go straight through during the data phase
	assign pk_ready = (state == st_data) && out.ready;

	always_comb begin
		word_valid = 1'b1;
		word.mode = sha3_256;
		word.block_last = (blk_cnt == 6'(RATE_SHA3_256_WORDS - 1));
		word.msg_last = (state == st_final);
		case (state)
			st_data: begin
				word_valid = pk_valid;
				word.data = pk_data;
			end
			st_domain: word.data = DOMAIN_SHA3_WORD;
			st_zero:   word.data = '0;
			st_final:  word.data = PAD_END_WORD;
			default: begin
				word_valid = 1'b0;
				word.data = '0;
			end
		endcase
	end

	assign out.word = word;
	assign out.valid = word_valid;
	// message counts as started once the first key word shows up
	assign out.busy = (state != st_idle) && ((total_cnt != '0) || word_valid);

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= st_idle;
			blk_cnt <= '0;
			total_cnt <= '0;
		end else if (state == st_idle) begin
			blk_cnt <= '0;
			total_cnt <= '0;
			if (pk_start)
				state <= st_data;
		end else if (fire) begin
			total_cnt <= total_cnt + 9'd1;
			if (blk_cnt == 6'(RATE_SHA3_256_WORDS - 1))
				blk_cnt <= '0;
			else
				blk_cnt <= blk_cnt + 6'd1;
			case (state)
				st_data: begin
					if (total_cnt == data_len - 9'd1)
						state <= st_domain;
				end
				st_domain, st_zero: begin
					if (total_cnt == total_len - 9'd2)
						state <= st_final;
					else
						state <= st_zero;
				end
				default: state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == st_idle && pk_start)
			k_q <= k;
	end

	a_rank_legal: assert property (@(posedge clk) disable iff (rst)
		pk_busy |-> k_q inside {3'd2, 3'd3, 3'd4});

endmodule

`default_nettype wire

//--- seed_framer.sv
`timescale 1ns/10ps
`default_nettype none

module seed_framer
	import kyber_frame_pkg::*;
(
	input  logic        clk,
	input  logic        rst,
	input  logic        seed_valid,
	output logic        seed_ready,
	input  seed_t       seed_data,
	input  logic        seed_xof,
	input  logic [3:0]  nonce,
	input  logic [1:0]  row,
	input  logic [1:0]  col,
	hash_word_if.source out
);

	typedef enum logic [1:0] {
		ph_idle,
		ph_seed,
		ph_suffix,
		ph_pad
	} phase_t;

	phase_t     phase;
	seed_t      seed_sr;
	logic       xof_q;
	logic [3:0] nonce_q;
	logic [1:0] row_q;
	logic [1:0] col_q;
	logic [5:0] word_cnt;
	logic [5:0] last_idx;
	logic       last_word;
	logic       fire;
	word_t      suffix_word;
	hash_word_t word;

	assign seed_ready = (phase == ph_idle);
	assign fire = out.valid && out.ready;

	// xof jobs use the shake128 rate, prf jobs the shake256 rate
	assign last_idx = xof_q ? 6'(RATE_SHAKE128_WORDS - 1) : 6'(RATE_SHAKE256_WORDS - 1);
	assign last_word = (word_cnt == last_idx);

	// xof suffix carries the matrix indices, prf suffix the nonce
	always_comb begin
		if (xof_q)
			suffix_word = {8'h00, SHAKE_SUFFIX, 6'h00, col_q, 6'h00, row_q};
		else
			suffix_word = {16'h0000, SHAKE_SUFFIX, 4'h0, nonce_q};
	end

	always_comb begin
		word.mode = xof_q ? shake128 : shake256;
		word.block_last = (phase == ph_pad) && last_word;
		word.msg_last = (phase == ph_pad) && last_word;
		case (phase)
			ph_seed:   word.data = seed_sr[31:0];
			ph_suffix: word.data = suffix_word;
			ph_pad:    word.data = last_word ? PAD_END_WORD : '0;
			default:   word.data = '0;
		endcase
	end

	assign out.word = word;
	assign out.valid = (phase != ph_idle);
	assign out.busy = (phase != ph_idle);

	always_ff @(posedge clk) begin
		if (rst) begin
			phase <= ph_idle;
			word_cnt <= '0;
		end else begin
			case (phase)
				ph_idle: begin
					if (seed_valid) begin
						phase <= ph_seed;
						word_cnt <= '0;
					end
				end
				ph_seed: begin
					if (fire) begin
						word_cnt <= word_cnt + 6'd1;
						if (word_cnt == 6'(SEED_WORDS - 1))
							phase <= ph_suffix;
					end
				end
				ph_suffix: begin
					if (fire) begin
						word_cnt <= word_cnt + 6'd1;
						phase <= ph_pad;
					end
				end
				default: begin
					if (fire) begin
						word_cnt <= word_cnt + 6'd1;
						if (last_word)
							phase <= ph_idle;
					end
				end
			endcase
		end
	end

	// seed register drops one word per transfer, lsw first
	always_ff @(posedge clk) begin
		if (seed_valid && seed_ready) begin
			seed_sr <= seed_data;
			xof_q <= seed_xof;
			nonce_q <= nonce;
			row_q <= row;
			col_q <= col;
		end else if (phase == ph_seed && fire) begin
			seed_sr <= {seed_sr[31:0], seed_sr[255:32]};
		end
	end

	// a stalled word stays on the stream until the arbiter takes it
	a_valid_held: assert property (@(posedge clk) disable iff (rst)
		out.valid && !out.ready |=> out.valid && $stable(out.word));

endmodule

`default_nettype wire

//--- hash_word_if.sv
`timescale 1ns/10ps
`default_nettype none

interface hash_word_if
	import kyber_frame_pkg::*;
();

	logic       valid;
	logic       ready;
	hash_word_t word;
	// high while a message is on its way out
	logic       busy;

	modport source (
		output valid,
		output word,
		output busy,
		input  ready
	);

	modport sink (
		input  valid,
		input  word,
		input  busy,
		output ready
	);

endinterface

`default_nettype wire

//--- kyber_frame_pkg.sv
`default_nettype none

package kyber_frame_pkg;

	typedef logic [31:0] word_t;
	typedef logic [255:0] seed_t;

	localparam int SEED_WORDS = 8;

	// sponge rates in 32-bit words
	localparam int RATE_SHA3_256_WORDS = 34;
	localparam int RATE_SHAKE128_WORDS = 42;
	localparam int RATE_SHAKE256_WORDS = 34;

	localparam word_t DOMAIN_SHA3_WORD = 32'h00000006;
	localparam logic [7:0] SHAKE_SUFFIX = 8'h1f;
	localparam word_t PAD_END_WORD = 32'h80000000;

	typedef enum logic [1:0] {
		sha3_256,
		shake128,
		shake256
	} sponge_mode_t;

	// one framed word as seen by the sponge core
	typedef struct packed {
		word_t        data;
		sponge_mode_t mode;
		logic         block_last;
		logic         msg_last;
	} hash_word_t;

	typedef logic [2:0] rank_t;

	// public key is k polynomials of 96 words plus the 8-word rho
	function automatic int unsigned pk_words(input rank_t k);
		return 96 * int'(k) + 8;
	endfunction

	// room for the domain word and the end word, rounded up to whole blocks
	function automatic int unsigned pk_total_words(input rank_t k);
		int unsigned blocks;
		blocks = (pk_words(k) + 2 + RATE_SHA3_256_WORDS - 1) / RATE_SHA3_256_WORDS;
		return blocks * RATE_SHA3_256_WORDS;
	endfunction

endpackage

`default_nettype wire
